/* testbench/fpu_misc_cases.txt */
// Columns are op, format, operand a, operand b, expected result and expected invalid
// Op 0 is class, 1 eq, 2 lt, 3 le, 4 min and 5 max, and format 1 is double
0_0_FFFFFFFFFF800000_0000000000000000_0000000000000001_0
0_0_FFFFFFFFBF800000_0000000000000000_0000000000000002_0
0_0_FFFFFFFF80000001_0000000000000000_0000000000000004_0
0_0_FFFFFFFF80000000_0000000000000000_0000000000000008_0
0_0_FFFFFFFF00000000_0000000000000000_0000000000000010_0
0_0_FFFFFFFF00400000_0000000000000000_0000000000000020_0
0_0_FFFFFFFF3F800000_0000000000000000_0000000000000040_0
0_0_FFFFFFFF7F800000_0000000000000000_0000000000000080_0
0_0_FFFFFFFF7F800001_0000000000000000_0000000000000100_0
0_0_FFFFFFFF7FC00000_0000000000000000_0000000000000200_0
0_0_000000003F800000_0000000000000000_0000000000000200_0
0_1_FFF0000000000000_0000000000000000_0000000000000001_0
0_1_BFF0000000000000_0000000000000000_0000000000000002_0
0_1_8000000000000001_0000000000000000_0000000000000004_0
0_1_8000000000000000_0000000000000000_0000000000000008_0
0_1_0000000000000000_0000000000000000_0000000000000010_0
0_1_0000000000000001_0000000000000000_0000000000000020_0
0_1_3FF0000000000000_0000000000000000_0000000000000040_0
0_1_7FF0000000000000_0000000000000000_0000000000000080_0
0_1_7FF0000000000001_0000000000000000_0000000000000100_0
0_1_7FF8000000000000_0000000000000000_0000000000000200_0
1_0_FFFFFFFF3F800000_FFFFFFFF3F800000_0000000000000001_0
1_0_FFFFFFFF00000000_FFFFFFFF80000000_0000000000000001_0
1_0_FFFFFFFF7FC00000_FFFFFFFF3F800000_0000000000000000_0
1_0_FFFFFFFF7F800001_FFFFFFFF3F800000_0000000000000000_1
2_0_FFFFFFFFBF800000_FFFFFFFF3F800000_0000000000000001_0
2_0_FFFFFFFFC0000000_FFFFFFFFBF800000_0000000000000001_0
2_0_FFFFFFFF00000001_FFFFFFFF00400000_0000000000000001_0
2_0_FFFFFFFF7FC00000_FFFFFFFF3F800000_0000000000000000_1
3_0_FFFFFFFF80000000_FFFFFFFF00000000_0000000000000001_0
2_1_0000000000000001_3FF0000000000000_0000000000000001_0
2_1_7FF0000000000000_4000000000000000_0000000000000000_0
3_1_FFF0000000000000_8000000000000001_0000000000000001_0
3_0_000000003F800000_FFFFFFFF3F800000_0000000000000000_1
1_0_FFFFFFFF3F800000_000000003F800000_0000000000000000_0
4_0_FFFFFFFF3F800000_FFFFFFFF40000000_FFFFFFFF3F800000_0
5_0_FFFFFFFFBF800000_FFFFFFFF40000000_FFFFFFFF40000000_0
4_0_FFFFFFFF00000000_FFFFFFFF80000000_FFFFFFFF80000000_0
5_0_FFFFFFFF80000000_FFFFFFFF00000000_FFFFFFFF00000000_0
4_0_FFFFFFFF7FC00000_FFFFFFFF40000000_FFFFFFFF40000000_0
5_0_FFFFFFFF7F800001_FFFFFFFFBF800000_FFFFFFFFBF800000_1
4_0_FFFFFFFF7FC00000_FFFFFFFF7F800001_FFFFFFFF7FC00000_1
5_1_7FF8000000000000_7FF8000000000000_7FF8000000000000_0
4_1_FFF0000000000000_3FF0000000000000_FFF0000000000000_0
5_1_7FF0000000000001_4000000000000000_4000000000000000_1
4_0_000000003F800000_FFFFFFFF40000000_FFFFFFFF40000000_0
5_0_123456783F800000_000000007F800001_FFFFFFFF7FC00000_0

/* all.f */
+incdir+design
design/fpu_pkg.sv
design/fpu_normalize_from_ieee.sv
design/fpu_normalize_from_ieee_multi.sv
design/fpu_classify.sv
design/fpu_compare.sv
design/fpu_misc_unit.sv
testbench/tb_clock_gen.sv
testbench/fpu_misc_unit_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the FPU misc unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module fpu_misc_unit_tb \
  -f all.f -o fpu_misc_sim
output=$(./obj_dir/fpu_misc_sim)
echo "$output"
if echo "$output" | grep -q "Everything OK"; then
  exit 0
else
  exit 1
fi

/* testbench/fpu_misc_unit_tb.sv */
`timescale 1ns/10ps

module fpu_misc_unit_tb;

  localparam int MaxCases = 64;
  localparam int Timeout  = 20;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  fpu_pkg::fpu_req_t  req;
  logic               resp_valid;
  fpu_pkg::fpu_resp_t resp;

  logic [203:0] cases_mem [MaxCases]; // op, format, a, b, result, invalid
  int           num_cases;
  int           errors;
  int           checks;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fpu_misc_unit UUT (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .valid_i (req_valid),
    .req_i   (req),
    .valid_o (resp_valid),
    .resp_o  (resp)
  );

  // **********************************************************************
  // Stimulus and checking
  // **********************************************************************

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic drive_case(input int idx);
    logic [203:0] entry;
    entry         = cases_mem[idx];
    req_valid     = 1'b1;
    req.op        = fpu_pkg::fpu_op_e'(entry[202:200]);
    req.double    = entry[196];
    req.operand_a = entry[195:132];
    req.operand_b = entry[131:68];
  endtask

  task automatic check_response(input int idx);
    logic [203:0] entry;
    entry = cases_mem[idx];
    check_value($sformatf("case %0d result", idx), resp.result, entry[67:4]);
    check_value($sformatf("case %0d invalid", idx), 64'(resp.invalid), 64'(entry[0]));
  endtask

  task automatic run_single(input int idx);
    int waits;
    @(negedge clk);
    drive_case(idx);
    @(negedge clk);
    req_valid = 1'b0;
    waits     = 0;
    while (!resp_valid && waits < Timeout) begin
      @(negedge clk);
      waits++;
    end
    if (!resp_valid) begin
      errors++;
      $display("Case %0d got no valid result within %0d cycles", idx, Timeout);
    end else begin
      check_value($sformatf("case %0d extra latency", idx), 64'(waits), 64'd0);
      check_response(idx);
      @(negedge clk);
      check_value($sformatf("case %0d repeated valid", idx), 64'(resp_valid), 64'd0);
    end
  endtask

  // Second request goes in while the first result comes out
  task automatic run_back_to_back(input int first, input int second);
    @(negedge clk);
    drive_case(first);
    @(negedge clk);
    drive_case(second);
    check_value("first back-to-back valid", 64'(resp_valid), 64'd1);
    check_response(first);
    @(negedge clk);
    req_valid = 1'b0;
    check_value("second back-to-back valid", 64'(resp_valid), 64'd1);
    check_response(second);
    @(negedge clk);
    check_value("valid after back-to-back", 64'(resp_valid), 64'd0);
  endtask

  initial begin
    int cycles;
    req_valid = 1'b0;
    req       = '0;
    errors    = 0;
    checks    = 0;
    num_cases = 0;
    for (int i = 0; i < MaxCases; i++) begin
      cases_mem[i] = '1; // All ones marks the end of the list
    end
    $readmemh("testbench/fpu_misc_cases.txt", cases_mem);
    while (num_cases < MaxCases && cases_mem[num_cases] != '1) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      errors++;
      $display("No test cases were read from the case file");
    end

    @(negedge clk);
    req_valid = 1'b1; // A request inside reset must not come out
    @(negedge clk);
    req_valid = 1'b0;

    cycles = 0;
    while (!rst_n && cycles < 50) begin
      check_value("valid during reset", 64'(resp_valid), 64'd0);
      check_value("result during reset", resp.result, 64'd0);
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) begin
      errors++;
      $display("Reset was never released");
    end
    repeat (3) begin
      @(negedge clk);
      check_value("valid after reset", 64'(resp_valid), 64'd0);
      check_value("result after reset", resp.result, 64'd0);
    end

    for (int i = 0; i < num_cases; i++) begin
      run_single(i);
    end
    if (num_cases >= 2) begin
      run_back_to_back(0, num_cases - 1);
    end

    $display("Cases: %0d, checks: %0d, errors: %0d", num_cases, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HalfPeriod  = 10,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o; // 20 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1; // Released away from the sampling edge
  end

endmodule

/* design/fpu_misc_unit.sv */
`timescale 1ns/10ps

module fpu_misc_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  fpu_pkg::fpu_req_t  req_i,
  output logic               valid_o,
  output fpu_pkg::fpu_resp_t resp_o
);

  fpu_pkg::fpu_decoded_t dec_a;
  fpu_pkg::fpu_decoded_t dec_b;
  logic [9:0]            class_mask;
  fpu_pkg::fpu_resp_t    cmp_resp;
  fpu_pkg::fpu_resp_t    resp_d;

  // **********************************************************************
  // Operand decode
  // **********************************************************************

  fpu_normalize_from_ieee_multi u_decode_a (
    .double_i  (req_i.double),
    .ieee_i    (req_i.operand_a),
    .decoded_o (dec_a)
  );

  fpu_normalize_from_ieee_multi u_decode_b (
    .double_i  (req_i.double),
    .ieee_i    (req_i.operand_b),
    .decoded_o (dec_b)
  );

  // **********************************************************************
  // Execution
  // **********************************************************************

  fpu_classify u_classify (
    .dec_i   (dec_a),
    .class_o (class_mask)
  );

  fpu_compare u_compare (
    .op_i        (req_i.op),
    .double_i    (req_i.double),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .dec_a_i     (dec_a),
    .dec_b_i     (dec_b),
    .resp_o      (cmp_resp)
  );

  always_comb begin
    if (req_i.op == fpu_pkg::OP_CLASS) begin
      resp_d.result  = {54'b0, class_mask};
      resp_d.invalid = 1'b0; // FCLASS never raises a flag
    end else begin
      resp_d = cmp_resp;
    end
  end

  // **********************************************************************
  // Output register
  // **********************************************************************

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      resp_o  <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        resp_o <= resp_d; // Held until the next request
      end
    end
  end

endmodule

/* design/fpu_compare.sv */
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_compare (
  input  fpu_pkg::fpu_op_e      op_i,
  input  logic                  double_i,
  input  logic [63:0]           operand_a_i,
  input  logic [63:0]           operand_b_i,
  input  fpu_pkg::fpu_decoded_t dec_a_i,
  input  fpu_pkg::fpu_decoded_t dec_b_i,
  output fpu_pkg::fpu_resp_t    resp_o
);

  logic        a_snan;
  logic        b_snan;
  logic        any_nan;
  logic        any_snan;
  logic        both_zero;
  logic        mag_a_lt_b;
  logic        mag_b_lt_a;
  logic        mag_eq;
  logic        val_eq;
  logic        val_lt;
  logic        minmax_a_lt_b;
  logic [63:0] boxed_a;
  logic [63:0] boxed_b;
  logic [63:0] canon_nan;

  // **********************************************************************
  // Ordering of the decoded values
  // **********************************************************************

  assign a_snan    = dec_a_i.is_nan & ~dec_a_i.significand[`FPU_OUT_SIG_WIDTH-1];
  assign b_snan    = dec_b_i.is_nan & ~dec_b_i.significand[`FPU_OUT_SIG_WIDTH-1];
  assign any_nan   = dec_a_i.is_nan | dec_b_i.is_nan;
  assign any_snan  = a_snan | b_snan;
  assign both_zero = dec_a_i.is_zero & dec_b_i.is_zero;

  // Zero is below every other magnitude and the rest go by exponent then fraction
  always_comb begin
    mag_eq     = both_zero;
    mag_a_lt_b = dec_a_i.is_zero & ~dec_b_i.is_zero;
    mag_b_lt_a = dec_b_i.is_zero & ~dec_a_i.is_zero;
    if (!dec_a_i.is_zero && !dec_b_i.is_zero) begin
      mag_eq     = (dec_a_i.exponent == dec_b_i.exponent) &&
                   (dec_a_i.significand == dec_b_i.significand);
      mag_a_lt_b = (dec_a_i.exponent < dec_b_i.exponent) ||
                   ((dec_a_i.exponent == dec_b_i.exponent) &&
                    (dec_a_i.significand < dec_b_i.significand));
      mag_b_lt_a = !mag_eq && !mag_a_lt_b;
    end
  end

  assign val_eq = both_zero | ((dec_a_i.sign == dec_b_i.sign) & mag_eq);

  always_comb begin
    if (both_zero) begin
      val_lt = 1'b0;
    end else if (dec_a_i.sign != dec_b_i.sign) begin
      val_lt = dec_a_i.sign; // Negative side is smaller
    end else begin
      val_lt = dec_a_i.sign ? mag_b_lt_a : mag_a_lt_b;
    end
  end

  // Min and max put -0 below +0
  assign minmax_a_lt_b = both_zero ? (dec_a_i.sign & ~dec_b_i.sign) : val_lt;

  // **********************************************************************
  // Result selection
  // **********************************************************************

  assign boxed_a   = double_i ? operand_a_i : {32'hFFFF_FFFF, operand_a_i[31:0]};
  assign boxed_b   = double_i ? operand_b_i : {32'hFFFF_FFFF, operand_b_i[31:0]};
  assign canon_nan = double_i ? `FPU_CANON_NAN_D : `FPU_CANON_NAN_S;

  always_comb begin
    resp_o = '0;
    unique case (op_i)
      fpu_pkg::OP_EQ: begin
        resp_o.result[0] = ~any_nan & val_eq;
        resp_o.invalid   = any_snan; // Quiet NaNs compare unordered silently
      end
      fpu_pkg::OP_LT: begin
        resp_o.result[0] = ~any_nan & val_lt;
        resp_o.invalid   = any_nan;
      end
      fpu_pkg::OP_LE: begin
        resp_o.result[0] = ~any_nan & (val_lt | val_eq);
        resp_o.invalid   = any_nan;
      end
      fpu_pkg::OP_MIN, fpu_pkg::OP_MAX: begin
        if (dec_a_i.is_nan && dec_b_i.is_nan) begin
          resp_o.result = canon_nan;
        end else if (dec_a_i.is_nan) begin
          resp_o.result = boxed_b;
        end else if (dec_b_i.is_nan) begin
          resp_o.result = boxed_a;
        end else if (op_i == fpu_pkg::OP_MIN) begin
          resp_o.result = minmax_a_lt_b ? boxed_a : boxed_b;
        end else begin
          resp_o.result = minmax_a_lt_b ? boxed_b : boxed_a;
        end
        resp_o.invalid = any_snan;
      end
      default: begin
        resp_o = '0; // FCLASS is produced elsewhere
      end
    endcase
  end

endmodule

/* design/fpu_classify.sv */
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_classify (
  input  fpu_pkg::fpu_decoded_t dec_i,
  output logic [9:0]            class_o
);

  logic quiet;

  assign quiet = dec_i.significand[`FPU_OUT_SIG_WIDTH-1];

  // RISC-V FCLASS mask with exactly one bit set
  always_comb begin
    class_o = '0;
    if (dec_i.is_nan) begin
      if (quiet) begin
        class_o[9] = 1'b1;
      end else begin
        class_o[8] = 1'b1;
      end
    end else if (dec_i.is_inf) begin
      class_o[dec_i.sign ? 0 : 7] = 1'b1;
    end else if (dec_i.is_normal) begin
      class_o[dec_i.sign ? 1 : 6] = 1'b1;
    end else if (dec_i.is_subnormal) begin
      class_o[dec_i.sign ? 2 : 5] = 1'b1;
    end else begin
      class_o[dec_i.sign ? 3 : 4] = 1'b1; // Zero
    end
  end

endmodule

/* design/fpu_normalize_from_ieee_multi.sv */
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_normalize_from_ieee_multi (
  input  logic                  double_i,
  input  logic [63:0]           ieee_i,
  output fpu_pkg::fpu_decoded_t decoded_o
);

  fpu_pkg::fpu_decoded_t single_dec;
  fpu_pkg::fpu_decoded_t double_dec;
  logic                  nan_boxed;

  // A single is only valid when the upper word is all ones
  assign nan_boxed = &ieee_i[63:32];

  // **********************************************************************
  // Format decoders
  // **********************************************************************

  fpu_normalize_from_ieee #(
    .IeeeExpWidth (`FPU_SINGLE_EXP_WIDTH),
    .IeeeSigWidth (`FPU_SINGLE_SIG_WIDTH)
  ) u_single_decode (
    .ieee_i    (ieee_i[31:0]),
    .decoded_o (single_dec)
  );

  fpu_normalize_from_ieee #(
    .IeeeExpWidth (`FPU_DOUBLE_EXP_WIDTH),
    .IeeeSigWidth (`FPU_DOUBLE_SIG_WIDTH)
  ) u_double_decode (
    .ieee_i    (ieee_i),
    .decoded_o (double_dec)
  );

  // **********************************************************************
  // Format selection
  // **********************************************************************

  always_comb begin
    if (double_i) begin
      decoded_o = double_dec;
    end else if (nan_boxed) begin
      decoded_o = single_dec;
    end else begin
      // Broken boxing reads as the canonical quiet NaN
      decoded_o                                       = '0;
      decoded_o.significand[`FPU_OUT_SIG_WIDTH-1]     = 1'b1;
      decoded_o.is_nan                                = 1'b1;
    end
  end

endmodule

/* design/fpu_normalize_from_ieee.sv */
`timescale 1ns/10ps
`include "fpu_config.svh"

module fpu_normalize_from_ieee #(
  parameter int IeeeExpWidth = 8,
  parameter int IeeeSigWidth = 23
) (
  input  logic [IeeeExpWidth+IeeeSigWidth:0] ieee_i,
  output fpu_pkg::fpu_decoded_t              decoded_o
);

  localparam int OutExpWidth = `FPU_OUT_EXP_WIDTH;
  localparam int OutSigWidth = `FPU_OUT_SIG_WIDTH;
  localparam int LzcWidth    = $clog2(IeeeSigWidth + 1);
  localparam logic [OutExpWidth-1:0] Bias = OutExpWidth'((1 << (IeeeExpWidth - 1)) - 1);

  logic                    sign;
  logic [IeeeExpWidth-1:0] exp_field;
  logic [IeeeSigWidth-1:0] frac_field;
  logic                    exp_all_ones;
  logic                    exp_all_zeros;
  logic                    frac_zero;
  logic [OutSigWidth-1:0]  frac_aligned;
  logic [LzcWidth-1:0]     lead_zeros;
  logic [LzcWidth-1:0]     shift_amt;

  assign sign       = ieee_i[IeeeExpWidth+IeeeSigWidth];
  assign exp_field  = ieee_i[IeeeExpWidth+IeeeSigWidth-1:IeeeSigWidth];
  assign frac_field = ieee_i[IeeeSigWidth-1:0];

  assign exp_all_ones  = &exp_field;
  assign exp_all_zeros = ~|exp_field;
  assign frac_zero     = ~|frac_field;

  // Fraction moved to the top of the internal field, so a NaN keeps its quiet bit on top
  assign frac_aligned = OutSigWidth'(frac_field) << (OutSigWidth - IeeeSigWidth);

  // Leading zero count of the fraction where the highest set bit wins
  always_comb begin
    lead_zeros = '0;
    for (int i = 0; i < IeeeSigWidth; i++) begin
      if (frac_field[i]) begin
        lead_zeros = LzcWidth'(IeeeSigWidth - 1 - i);
      end
    end
  end

  assign shift_amt = lead_zeros + LzcWidth'(1); // One more to hide the leading one

  always_comb begin
    decoded_o             = '0;
    decoded_o.sign        = sign;
    decoded_o.exponent    = OutExpWidth'(exp_field) - Bias;
    decoded_o.significand = frac_aligned;
    if (exp_all_ones) begin
      decoded_o.is_inf = frac_zero;
      decoded_o.is_nan = !frac_zero;
    end else if (exp_all_zeros) begin
      if (frac_zero) begin
        decoded_o.exponent = '0;
        decoded_o.is_zero  = 1'b1;
      end else begin
        // Normalize a subnormal and pull the exponent down by the same amount
        decoded_o.exponent     = OutExpWidth'(1) - Bias - OutExpWidth'(shift_amt);
        decoded_o.significand  = frac_aligned << shift_amt;
        decoded_o.is_subnormal = 1'b1;
      end
    end else begin
      decoded_o.is_normal = 1'b1;
    end
  end

endmodule

/* design/fpu_pkg.sv */
`include "fpu_config.svh"

package fpu_pkg;

  // Non-arithmetic operations handled by the misc unit
  typedef enum logic [2:0] {
    OP_CLASS,
    OP_EQ,
    OP_LT,
    OP_LE,
    OP_MIN,
    OP_MAX
  } fpu_op_e;

  typedef struct packed {
    logic                                 sign;
    logic signed [`FPU_OUT_EXP_WIDTH-1:0] exponent;    // Unbiased
    logic [`FPU_OUT_SIG_WIDTH-1:0]        significand; // Top bit is the quiet bit for NaNs
    logic                                 is_normal;
    logic                                 is_zero;
    logic                                 is_subnormal;
    logic                                 is_inf;
    logic                                 is_nan;
  } fpu_decoded_t;

  typedef struct packed {
    fpu_op_e     op;
    logic        double;    // Set for binary64 operands
    logic [63:0] operand_a;
    logic [63:0] operand_b;
  } fpu_req_t;

  typedef struct packed {
    logic [63:0] result;
    logic        invalid; // NV flag
  } fpu_resp_t;

endpackage

/* design/fpu_config.svh */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// IEEE 754 binary32 fields
`define FPU_SINGLE_EXP_WIDTH 8
`define FPU_SINGLE_SIG_WIDTH 23

// IEEE 754 binary64 fields
`define FPU_DOUBLE_EXP_WIDTH 11
`define FPU_DOUBLE_SIG_WIDTH 52

// Internal decoded format shared by both precisions
`define FPU_OUT_EXP_WIDTH 12 // Signed and wide enough for the lowest double subnormal
`define FPU_OUT_SIG_WIDTH 52 // Fraction below the hidden one

// Canonical quiet NaNs as written back to the register file
`define FPU_CANON_NAN_S 64'hFFFF_FFFF_7FC0_0000 // NaN-boxed single
`define FPU_CANON_NAN_D 64'h7FF8_0000_0000_0000

`endif
